// File: bench/ossc_out_asserts.sv
/*
 * Protocol and output sanity properties, bound to the top level of the
 * scan converter output side.
 */
`timescale 1ns/1ps

module ossc_out_asserts import ossc_pkg::*; (
    input logic              pclk_out,
    input logic              po_reset_n,
    input logic [CTRL_W-1:0] sys_ctrl_i,
    input logic              refresh_req_o,
    input logic              refresh_ack_i,
    input logic [RGB_W-1:0]  tx_rgb_o,
    input logic              tx_hsync_o,
    input logic              tx_vsync_o,
    input logic              tx_de_o,
    input logic [2:0]        led_o
);

    // Four-phase rule, req held until ack arrives
    req_holds: assert property (@(posedge pclk_out) disable iff (!po_reset_n)
        refresh_req_o && !refresh_ack_i |=> refresh_req_o)
        else $error("refresh req dropped before ack");

    req_waits_ack_low: assert property (@(posedge pclk_out) disable iff (!po_reset_n)
        !refresh_req_o && refresh_ack_i |=> !refresh_req_o)
        else $error("refresh req raised while ack high");

    tx_known: assert property (@(posedge pclk_out) disable iff (!po_reset_n)
        !$isunknown({tx_rgb_o, tx_hsync_o, tx_vsync_o, tx_de_o}))
        else $error("transmitter outputs unknown");

    // LEDs are registered, so allow one cycle after power drops
    off_leds: assert property (@(posedge pclk_out) disable iff (!po_reset_n)
        !sys_ctrl_i[SYS_POWERON_BIT] && $past(!sys_ctrl_i[SYS_POWERON_BIT])
        |-> led_o[2:1] == 2'b00)
        else $error("status LEDs lit while powered down");

endmodule

bind ossc_out_top ossc_out_asserts u_asserts (
    .pclk_out(pclk_out), .po_reset_n(po_reset_n), .sys_ctrl_i(sys_ctrl_i),
    .refresh_req_o(refresh_req_o), .refresh_ack_i(refresh_ack_i),
    .tx_rgb_o(tx_rgb_o), .tx_hsync_o(tx_hsync_o), .tx_vsync_o(tx_vsync_o),
    .tx_de_o(tx_de_o), .led_o(led_o)
);

// File: bench/tb_ossc_out.sv
/*
 * Testbench for the scan converter output side: overlay pipeline, PWM,
 * buttons, status LEDs, refresh handshake and power-off behavior.
 */
`timescale 1ns/1ps

module tb_ossc_out import ossc_pkg::*; ;

    localparam int MAX_CYCLES = 6000;

    logic pclk_out = 1'b0;
    logic po_reset_n;
    logic [CTRL_W-1:0] sys_ctrl_i;
    logic [RGB_W-1:0] sc_rgb_i, tx_rgb_o;
    logic sc_hsync_i, sc_vsync_i, sc_de_i, osd_enable_i;
    logic [OSD_COLOR_W-1:0] osd_color_i;
    logic [BTN_W-1:0] btn_i, btn_o;
    logic [IR_CODE_W-1:0] ir_code_i;
    logic resync_strobe_i, pll_locked_i, refresh_ack_i;
    logic tx_hsync_o, tx_vsync_o, tx_de_o, fan_pwm_o, tx_5v_en_o, refresh_req_o;
    logic [2:0] led_o;

    integer seed = 32'h134e_a0aa;
    integer errors = 0;
    integer checks = 0;
    integer cyc = 0;
    integer hist_n = 0;
    integer req_rises = 0;
    logic req_seen = 1'b0;
    bit video_on = 0;
    logic [RGB_W-1:0] h_rgb[2];
    logic [2:0] h_sync[2];
    logic h_en[2];
    logic [OSD_COLOR_W-1:0] h_col[2];
    logic [BTN_W-1:0] h_btn[2];

    ossc_out_top #(.PWM_PERIOD(64), .LED_HOLD_W(6), .REFRESH_INTERVAL(40)) DUT (.*);

    always #10 pclk_out = ~pclk_out;

    always @(posedge pclk_out) begin
        cyc = cyc + 1;
        if (cyc >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    function automatic logic [RGB_W-1:0] exp_pixel(input logic [RGB_W-1:0] rgb,
                                                   input logic en,
                                                   input logic [OSD_COLOR_W-1:0] col);
        logic [RGB_W-1:0] pal[4];
        pal = '{OSD_BLACK, OSD_BLUE, OSD_YELLOW, OSD_WHITE};
        return en ? pal[col] : rgb;
    endfunction

    // Cycles per 64-cycle period with the channel high
    function automatic integer exp_active(input logic [DUTY_W-1:0] duty);
        return (duty == 4'd15) ? 64 : duty * 4;
    endfunction

    function automatic logic [2:0] exp_led(input logic pwr, input logic flock,
                                           input logic [IR_CODE_W-1:0] ir, input logic held);
        return pwr ? {flock, ir == 0, held} : 3'b001;
    endfunction

    function automatic logic [CTRL_W-1:0] make_ctrl(input logic pwr, input logic flock,
            input logic [DUTY_W-1:0] fan, input logic [DUTY_W-1:0] led, input logic ref_en);
        logic [CTRL_W-1:0] w;
        w = '0;
        w[SYS_POWERON_BIT] = pwr;
        w[FRAMELOCK_BIT] = flock;
        w[FAN_DUTY_LSB +: DUTY_W] = fan;
        w[LED_DUTY_LSB +: DUTY_W] = led;
        w[REFRESH_ENABLE_BIT] = ref_en;
        return w;
    endfunction

    task automatic check_rgb(input string name, input logic [RGB_W-1:0] exp, act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_led(input string name, input logic [2:0] exp, act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_btn(input string name, input logic [BTN_W-1:0] exp, act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input integer exp, act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic next_cycle();
        @(posedge pclk_out);
        #2;
    endtask

    // Overlay and button outputs against inputs from two cycles earlier
    always @(negedge pclk_out) begin
        if (video_on) begin
            if (hist_n >= 2) begin
                check_rgb("overlay pixel", exp_pixel(h_rgb[1], h_en[1], h_col[1]), tx_rgb_o);
                check_count("sync alignment", h_sync[1], {tx_hsync_o, tx_vsync_o, tx_de_o});
                check_btn("button sync", h_btn[1], btn_o);
            end
            h_rgb[1] = h_rgb[0];
            h_sync[1] = h_sync[0];
            h_en[1] = h_en[0];
            h_col[1] = h_col[0];
            h_btn[1] = h_btn[0];
            h_rgb[0] = sc_rgb_i;
            h_sync[0] = {sc_hsync_i, sc_vsync_i, sc_de_i};
            h_en[0] = osd_enable_i;
            h_col[0] = osd_color_i;
            h_btn[0] = btn_i;
            hist_n++;
        end
    end

    // Refresh requests raised by the DUT
    always @(negedge pclk_out) begin
        if (refresh_req_o && !req_seen)
            req_rises++;
        req_seen = refresh_req_o;
    end

    initial begin : main
        integer i, k, cnt, first_hi, last_hi, done, rises0, rise_gap, last_low;
        logic [IR_CODE_W-1:0] ir;
        logic flock, prev0;
        logic [DUTY_W-1:0] duties[3];
        po_reset_n = 1'b0;
        sys_ctrl_i = '0;
        {sc_rgb_i, sc_hsync_i, sc_vsync_i, sc_de_i, osd_enable_i, osd_color_i} = '0;
        btn_i = '1;
        ir_code_i = '0;
        {resync_strobe_i, pll_locked_i, refresh_ack_i} = 3'b010;
        @(negedge pclk_out);
        check_btn("buttons in reset", '1, btn_o);
        repeat (3) @(posedge pclk_out);
        #2 po_reset_n = 1'b1;

        sys_ctrl_i = make_ctrl(1, 0, 0, 15, 0);
        video_on = 1;
        for (i = 0; i < 500; i++) begin
            sc_rgb_i = $random(seed);
            {sc_hsync_i, sc_vsync_i, sc_de_i, osd_enable_i} = $random(seed);
            osd_color_i = $random(seed);
            btn_i = $random(seed);
            next_cycle();
        end
        video_on = 0;

        duties = '{4'd0, 4'd5, 4'd15};
        for (k = 0; k < 3; k++) begin
            next_cycle();
            sys_ctrl_i = make_ctrl(1, 0, duties[k], 15, 0);
            repeat (70) @(posedge pclk_out);
            cnt = 0;
            repeat (64) @(negedge pclk_out) cnt += (fan_pwm_o == 1'b0);
            check_count("fan low cycles", exp_active(duties[k]), cnt);
        end
        next_cycle();
        sys_ctrl_i = make_ctrl(0, 0, 15, 15, 0);
        cnt = 0;
        repeat (64) @(negedge pclk_out) cnt += (fan_pwm_o == 1'b0);
        check_count("fan off when powered down", 0, cnt);

        for (k = 0; k < 6; k++) begin
            next_cycle();
            flock = $random(seed);
            ir = ($random(seed) & 1) ? '0 : $random(seed);
            ir_code_i = ir;
            sys_ctrl_i = make_ctrl(1, flock, 0, 15, 0);
            repeat (4) @(negedge pclk_out);
            check_led("status LEDs", exp_led(1, flock, ir, 0), led_o);
        end
        next_cycle();
        resync_strobe_i = 1'b1;
        next_cycle();
        resync_strobe_i = 1'b0;
        first_hi = -1;
        last_hi = -1;
        for (i = 0; i < 80; i++) begin
            @(negedge pclk_out);
            if (led_o[0]) begin
                if (first_hi < 0)
                    first_hi = i;
                last_hi = i;
            end
        end
        if (first_hi < 0 || first_hi > 5 || last_hi - first_hi + 1 < 58 || last_hi >= 70) begin
            errors++;
            $display("Resync LED window wrong: high from cycle %0d to %0d", first_hi, last_hi);
        end

        next_cycle();
        sys_ctrl_i = make_ctrl(1, 0, 0, 15, 1);
        last_low = cyc;
        rises0 = req_rises;
        for (k = 0; k < 10; k++) begin
            next_cycle();
            while (!refresh_req_o)
                next_cycle();
            rise_gap = cyc - last_low;
            if (rise_gap < 40) begin
                errors++;
                $display("Refresh request came %0d cycles after ack low", rise_gap);
            end
            repeat (1 + $unsigned($random(seed)) % 4) @(posedge pclk_out);
            #2 refresh_ack_i = 1'b1;
            while (refresh_req_o)
                next_cycle();
            repeat (1 + $unsigned($random(seed)) % 4) @(posedge pclk_out);
            #2 refresh_ack_i = 1'b0;
            last_low = cyc;
        end
        done = req_rises - rises0;
        check_count("refreshes completed", 10, done);
        sys_ctrl_i = make_ctrl(1, 0, 0, 15, 0);
        cnt = 0;
        repeat (120) @(negedge pclk_out) cnt += refresh_req_o;
        check_count("requests while disabled", 0, cnt);

        next_cycle();
        sys_ctrl_i = make_ctrl(0, 0, 0, 15, 0);
        repeat (5) @(negedge pclk_out);
        check_led("power off locked", exp_led(0, 0, 0, 0), led_o);
        check_count("5V enable off", 0, tx_5v_en_o);
        next_cycle();
        pll_locked_i = 1'b0;
        prev0 = led_o[0];
        cnt = 0;
        repeat (70) @(negedge pclk_out) cnt += (led_o[0] != prev0);
        if (cnt == 0) begin
            errors++;
            $display("Power-off LED did not blink with the PLL unlocked");
        end

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// File: board/front_panel.sv
/*
 * Front panel housekeeping: button synchronizers, resync indication hold
 * counter and the three status LEDs, dimmed by the LED PWM.
 */
`timescale 1ns/1ps

module front_panel import ossc_pkg::*; #(
    parameter int HOLD_W = DEF_LED_HOLD_W
) (
    input  logic                 pclk_out,
    input  logic                 po_reset_n,
    input  logic [BTN_W-1:0]     btn_i,
    input  logic [IR_CODE_W-1:0] ir_code_i,
    input  logic                 resync_strobe_i,
    input  logic                 pll_locked_i,
    input  logic                 poweron_i,
    input  logic                 framelock_i,
    input  logic                 led_pwm_i,
    output logic [BTN_W-1:0]     btn_o,
    output logic [2:0]           led_o
);

    logic [BTN_W-1:0]  btn_sync1;
    logic              strobe_sync1;
    logic              strobe_sync2;
    logic              strobe_prev;
    logic              strobe_rise;
    logic [HOLD_W-1:0] hold_cnt;
    logic [2:0]        led_state;

    // Buttons are active low, released after reset
    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            btn_sync1 <= '1;
            btn_o <= '1;
        end else begin
            btn_sync1 <= btn_i;
            btn_o <= btn_sync1;
        end
    end

    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            {strobe_sync1, strobe_sync2, strobe_prev} <= 3'b000;
        end else begin
            strobe_sync1 <= resync_strobe_i;
            strobe_sync2 <= strobe_sync1;
            strobe_prev <= strobe_sync2;
        end
    end

    assign strobe_rise = strobe_sync2 & ~strobe_prev;

    // Powered down and unlocked, free running wrap makes bit 0 blink
    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            hold_cnt <= '0;
        end else if (poweron_i) begin
            if (strobe_rise) begin
                hold_cnt <= '1;
            end else if (hold_cnt != '0) begin
                hold_cnt <= hold_cnt - 1'b1;
            end
        end else if (pll_locked_i) begin
            hold_cnt <= '0;
        end else begin
            hold_cnt <= hold_cnt - 1'b1;
        end
    end

    // Bit order is blue, green, red
    assign led_state = poweron_i ? {framelock_i, (ir_code_i == '0), (hold_cnt != '0)}
                                 : {2'b00, ~hold_cnt[HOLD_W-1]};

    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            led_o <= 3'b000;
        end else begin
            led_o <= {3{led_pwm_i}} & led_state;
        end
    end

endmodule

// File: board/pwm_2ch.sv
/*
 * Two PWM channels sharing one period counter, used for the fan and the
 * LED brightness. Duty is in sixteenths of PERIOD, 15 gives a steady high.
 */
`timescale 1ns/1ps

module pwm_2ch import ossc_pkg::*; #(
    parameter int PERIOD = DEF_PWM_PERIOD
) (
    input  logic              pclk_out,
    input  logic              po_reset_n,
    input  logic [DUTY_W-1:0] ch1_duty_i,
    input  logic [DUTY_W-1:0] ch2_duty_i,
    output logic              ch1_pwm_o,
    output logic              ch2_pwm_o
);

    localparam int CNT_W = $clog2(PERIOD);

    logic [CNT_W-1:0]  period_cnt;
    logic [DUTY_W-1:0] phase;

    function automatic logic duty_on(input logic [DUTY_W-1:0] duty, input logic [DUTY_W-1:0] ph);
        return (duty == '1) || (ph < duty);
    endfunction

    // Top bits of the counter give the phase in sixteenths
    assign phase = period_cnt[CNT_W-1 -: DUTY_W];

    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            period_cnt <= '0;
            ch1_pwm_o <= 1'b0;
            ch2_pwm_o <= 1'b0;
        end else begin
            period_cnt <= period_cnt + 1'b1;
            ch1_pwm_o <= duty_on(ch1_duty_i, phase);
            ch2_pwm_o <= duty_on(ch2_duty_i, phase);
        end
    end

endmodule

// File: common/ossc_pkg.sv
/*
 * Shared widths, control word bit map, OSD palette and default parameters
 * for the output side of the scan converter. Imported by every RTL block.
 */
package ossc_pkg;

    // Pixel format
    localparam int COLOR_W = 8;
    localparam int RGB_W = 3 * COLOR_W;

    // OSD colour index and its palette
    localparam int OSD_COLOR_W = 2;
    localparam logic [RGB_W-1:0] OSD_BLACK = 24'h000000;
    localparam logic [RGB_W-1:0] OSD_BLUE = 24'h0000ff;
    localparam logic [RGB_W-1:0] OSD_YELLOW = 24'hffff00;
    localparam logic [RGB_W-1:0] OSD_WHITE = 24'hffffff;

    // System control word as written by the CPU
    localparam int CTRL_W = 32;
    localparam int SYS_POWERON_BIT = 0;
    localparam int FRAMELOCK_BIT = 14;
    localparam int FAN_DUTY_LSB = 16;
    localparam int LED_DUTY_LSB = 20;
    localparam int REFRESH_ENABLE_BIT = 24;

    // PWM duty, 15 means always on
    localparam int DUTY_W = 4;

    // Front panel
    localparam int BTN_W = 6;
    localparam int IR_CODE_W = 16;

    // Board defaults, overridden for short simulations
    localparam int DEF_PWM_PERIOD = 1024;
    localparam int DEF_LED_HOLD_W = 24;
    localparam int DEF_REFRESH_INTERVAL = 842;

endpackage

// File: flist.f
common/ossc_pkg.sv
video/osd_overlay.sv
board/pwm_2ch.sv
board/front_panel.sv
memory/dram_refresh_sched.sv
logic/ossc_out_top.sv
bench/ossc_out_asserts.sv
bench/tb_ossc_out.sv

// File: logic/ossc_out_top.sv
/*
 * Output side of the scan converter: OSD overlay and HDMI TX launch,
 * fan/LED PWM, front panel and DRAM refresh scheduling on pclk_out.
 */
`timescale 1ns/1ps

module ossc_out_top import ossc_pkg::*; #(
    parameter int PWM_PERIOD = DEF_PWM_PERIOD,
    parameter int LED_HOLD_W = DEF_LED_HOLD_W,
    parameter int REFRESH_INTERVAL = DEF_REFRESH_INTERVAL
) (
    input  logic                   pclk_out,
    input  logic                   po_reset_n,
    input  logic [CTRL_W-1:0]      sys_ctrl_i,
    input  logic [RGB_W-1:0]       sc_rgb_i,
    input  logic                   sc_hsync_i,
    input  logic                   sc_vsync_i,
    input  logic                   sc_de_i,
    input  logic                   osd_enable_i,
    input  logic [OSD_COLOR_W-1:0] osd_color_i,
    input  logic [BTN_W-1:0]       btn_i,
    input  logic [IR_CODE_W-1:0]   ir_code_i,
    input  logic                   resync_strobe_i,
    input  logic                   pll_locked_i,
    input  logic                   refresh_ack_i,
    output logic [RGB_W-1:0]       tx_rgb_o,
    output logic                   tx_hsync_o,
    output logic                   tx_vsync_o,
    output logic                   tx_de_o,
    output logic [BTN_W-1:0]       btn_o,
    output logic [2:0]             led_o,
    output logic                   fan_pwm_o,
    output logic                   tx_5v_en_o,
    output logic                   refresh_req_o
);

    logic              poweron;
    logic              framelock;
    logic [DUTY_W-1:0] fan_duty;
    logic [DUTY_W-1:0] led_duty;
    logic              refresh_enable;
    logic              fan_pwm;
    logic              led_pwm;

    // Control word fields
    assign poweron = sys_ctrl_i[SYS_POWERON_BIT];
    assign framelock = sys_ctrl_i[FRAMELOCK_BIT];
    assign fan_duty = sys_ctrl_i[FAN_DUTY_LSB +: DUTY_W];
    assign led_duty = sys_ctrl_i[LED_DUTY_LSB +: DUTY_W];
    assign refresh_enable = sys_ctrl_i[REFRESH_ENABLE_BIT];

    // Fan driver is active low, off while powered down
    assign fan_pwm_o = ~(poweron & fan_pwm);
    assign tx_5v_en_o = poweron;

    osd_overlay u_osd_overlay (
        .pclk_out     (pclk_out),
        .po_reset_n   (po_reset_n),
        .rgb_i        (sc_rgb_i),
        .hsync_i      (sc_hsync_i),
        .vsync_i      (sc_vsync_i),
        .de_i         (sc_de_i),
        .osd_enable_i (osd_enable_i),
        .osd_color_i  (osd_color_i),
        .rgb_o        (tx_rgb_o),
        .hsync_o      (tx_hsync_o),
        .vsync_o      (tx_vsync_o),
        .de_o         (tx_de_o)
    );

    pwm_2ch #(.PERIOD(PWM_PERIOD)) u_pwm (
        .pclk_out   (pclk_out),
        .po_reset_n (po_reset_n),
        .ch1_duty_i (fan_duty),
        .ch2_duty_i (led_duty),
        .ch1_pwm_o  (fan_pwm),
        .ch2_pwm_o  (led_pwm)
    );

    front_panel #(.HOLD_W(LED_HOLD_W)) u_front_panel (
        .pclk_out        (pclk_out),
        .po_reset_n      (po_reset_n),
        .btn_i           (btn_i),
        .ir_code_i       (ir_code_i),
        .resync_strobe_i (resync_strobe_i),
        .pll_locked_i    (pll_locked_i),
        .poweron_i       (poweron),
        .framelock_i     (framelock),
        .led_pwm_i       (led_pwm),
        .btn_o           (btn_o),
        .led_o           (led_o)
    );

    dram_refresh_sched #(.INTERVAL(REFRESH_INTERVAL)) u_refresh_sched (
        .pclk_out      (pclk_out),
        .po_reset_n    (po_reset_n),
        .enable_i      (refresh_enable),
        .refresh_ack_i (refresh_ack_i),
        .refresh_req_o (refresh_req_o)
    );

endmodule

// File: memory/dram_refresh_sched.sv
/*
 * Periodic DRAM refresh requests toward the memory controller using a
 * four-phase req/ack exchange. Interval restarts once ack is seen low.
 */
`timescale 1ns/1ps

module dram_refresh_sched import ossc_pkg::*; #(
    parameter int INTERVAL = DEF_REFRESH_INTERVAL
) (
    input  logic pclk_out,
    input  logic po_reset_n,
    input  logic enable_i,
    input  logic refresh_ack_i,
    output logic refresh_req_o
);

    localparam int CNT_W = $clog2(INTERVAL + 1);
    localparam logic [1:0] ST_COUNT = 2'd0;
    localparam logic [1:0] ST_REQ = 2'd1;
    localparam logic [1:0] ST_ACK_LOW = 2'd2;

    logic [1:0]       state;
    logic [CNT_W-1:0] cnt;

    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            state <= ST_COUNT;
            cnt <= '0;
        end else begin
            case (state)
                ST_COUNT: begin
                    if (!enable_i) begin
                        cnt <= '0;
                    end else if (cnt == CNT_W'(INTERVAL - 1) && !refresh_ack_i) begin
                        cnt <= '0;
                        state <= ST_REQ;
                    end else if (cnt != CNT_W'(INTERVAL - 1)) begin
                        cnt <= cnt + 1'b1;
                    end
                end
                // A raised request always completes, even if disabled
                ST_REQ: begin
                    if (refresh_ack_i)
                        state <= ST_ACK_LOW;
                end
                default: begin
                    if (!refresh_ack_i)
                        state <= ST_COUNT;
                end
            endcase
        end
    end

    assign refresh_req_o = (state == ST_REQ);

endmodule

// File: video/osd_overlay.sv
/*
 * OSD colour substitution on the scaler output followed by the HDMI TX
 * launch register. Fixed two-cycle latency, one pixel per clock.
 */
`timescale 1ns/1ps

module osd_overlay import ossc_pkg::*; (
    input  logic                   pclk_out,
    input  logic                   po_reset_n,
    input  logic [RGB_W-1:0]       rgb_i,
    input  logic                   hsync_i,
    input  logic                   vsync_i,
    input  logic                   de_i,
    input  logic                   osd_enable_i,
    input  logic [OSD_COLOR_W-1:0] osd_color_i,
    output logic [RGB_W-1:0]       rgb_o,
    output logic                   hsync_o,
    output logic                   vsync_o,
    output logic                   de_o
);

    logic [RGB_W-1:0] osd_rgb;
    logic [RGB_W-1:0] rgb_q;
    logic             hsync_q;
    logic             vsync_q;
    logic             de_q;

    always_comb begin
        case (osd_color_i)
            2'd0:    osd_rgb = OSD_BLACK;
            2'd1:    osd_rgb = OSD_BLUE;
            2'd2:    osd_rgb = OSD_YELLOW;
            default: osd_rgb = OSD_WHITE;
        endcase
    end

    // Stage one: overlay, syncs delayed alongside
    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            rgb_q <= '0;
            {hsync_q, vsync_q, de_q} <= 3'b000;
        end else begin
            rgb_q <= osd_enable_i ? osd_rgb : rgb_i;
            {hsync_q, vsync_q, de_q} <= {hsync_i, vsync_i, de_i};
        end
    end

    // Stage two: launch toward the transmitter pins
    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            rgb_o <= '0;
            {hsync_o, vsync_o, de_o} <= 3'b000;
        end else begin
            rgb_o <= rgb_q;
            {hsync_o, vsync_o, de_o} <= {hsync_q, vsync_q, de_q};
        end
    end

endmodule
